// ==== rtl/cpu_isa_pkg.sv ====
// instruction set of the 16-bit accumulator processor: word types, opcodes, fields
package cpu_isa_pkg;

    // data and instruction word
    typedef logic [15:0] word_t;

    // word address into the shared memory
    typedef logic [11:0] addr_t;

    // major opcode in bits 15:12
    // codes 4, 6, 7 and 15 are not decoded and behave as nop
    typedef enum logic [3:0] {
        OP_NOARG = 4'd0,
        OP_LDW   = 4'd1,
        OP_STW   = 4'd2,
        OP_ADD   = 4'd3,
        OP_SUB   = 4'd5,
        OP_AND   = 4'd8,
        OP_OR    = 4'd9,
        OP_XOR   = 4'd10,
        OP_JMP   = 4'd11,
        OP_JPZ   = 4'd12,
        OP_JPC   = 4'd13,
        OP_JPS   = 4'd14
    } opcode_e;

    // minor code in bits 3:0, only meaningful under OP_NOARG
    typedef enum logic [3:0] {
        NA_NOP = 4'd0,
        NA_INC = 4'd1,
        NA_DEC = 4'd2,
        NA_NOT = 4'd5,
        NA_MWO = 4'd9,
        NA_CLO = 4'd12
    } noarg_e;

    typedef struct packed {
        opcode_e opcode;
        addr_t   arg;
    } instr_t;

endpackage

// ==== rtl/cpu_ctrl_pkg.sv ====
// internal control types of the processor: sequencer state, execute ops, flags, buses
package cpu_ctrl_pkg;

    import cpu_isa_pkg::*;

    typedef enum logic [1:0] {
        S_FETCH,
        S_DECODE,
        S_EXEC
    } seq_state_e;

    // command from the sequencer to the execute unit
    typedef enum logic [3:0] {
        AC_NONE,
        AC_LOAD,
        AC_ADD,
        AC_SUB,
        AC_AND,
        AC_OR,
        AC_XOR,
        AC_INC,
        AC_DEC,
        AC_NOT,
        AC_MWO,
        AC_CLO
    } acc_op_e;

    typedef struct packed {
        logic zero;
        logic carry;
        logic sign;
    } flags_t;

    // core side memory access, at most one strobe per cycle
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
    } mem_req_t;

    // program load port, used while the core is held in reset
    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t data;
    } prog_wr_t;

endpackage

// ==== rtl/sequencer.sv ====
// fetch, decode and execute control with program counter and instruction register
`timescale 1ns/1ps

module sequencer
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  word_t    rd_data,
    input  flags_t   flags,
    output mem_req_t mem_req,
    output acc_op_e  acc_op
);

    seq_state_e state;
    addr_t      pc;
    instr_t     ir;
    instr_t     cur;
    logic       take_jump;
    logic       needs_operand;

    // memory operand opcodes and the op they issue in S_EXEC
    function automatic acc_op_e operand_op(opcode_e op);
        acc_op_e res;
        case (op)
            OP_LDW:  res = AC_LOAD;
            OP_ADD:  res = AC_ADD;
            OP_SUB:  res = AC_SUB;
            OP_AND:  res = AC_AND;
            OP_OR:   res = AC_OR;
            OP_XOR:  res = AC_XOR;
            default: res = AC_NONE;
        endcase
        return res;
    endfunction

    function automatic acc_op_e noarg_op(noarg_e na);
        acc_op_e res;
        case (na)
            NA_INC:  res = AC_INC;
            NA_DEC:  res = AC_DEC;
            NA_NOT:  res = AC_NOT;
            NA_MWO:  res = AC_MWO;
            NA_CLO:  res = AC_CLO;
            default: res = AC_NONE;
        endcase
        return res;
    endfunction

    // instruction word arriving from the fetch read
    assign cur = instr_t'(rd_data);
    assign needs_operand = (operand_op(cur.opcode) != AC_NONE);

    always_comb begin
        mem_req   = '0;
        acc_op    = AC_NONE;
        take_jump = 1'b0;
        case (state)
            S_FETCH: begin
                // no fetch while held in reset, first read right after release
                mem_req.rd   = !reset;
                mem_req.addr = pc;
            end
            S_DECODE: begin
                mem_req.addr = cur.arg;
                case (cur.opcode)
                    OP_STW: mem_req.wr = 1'b1;
                    OP_JMP: take_jump = 1'b1;
                    OP_JPZ: take_jump = flags.zero;
                    OP_JPC: take_jump = flags.carry;
                    OP_JPS: take_jump = flags.sign;
                    OP_NOARG: acc_op = noarg_op(noarg_e'(cur.arg[3:0]));
                    default: mem_req.rd = needs_operand;
                endcase
            end
            S_EXEC: begin
                // operand is on rd_data now
                acc_op = operand_op(ir.opcode);
            end
            default: begin
                acc_op = AC_NONE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
            pc    <= '0;
        end else begin
            case (state)
                S_FETCH: begin
                    state <= S_DECODE;
                end
                S_DECODE: begin
                    pc    <= take_jump ? cur.arg : pc + 1'b1;
                    state <= needs_operand ? S_EXEC : S_FETCH;
                end
                default: begin
                    state <= S_FETCH;
                end
            endcase
        end
    end

    // held for the operand cycle
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            ir <= cur;
        end
    end

endmodule

// ==== rtl/word_ram.sv ====
// synchronous single-port word memory, the program load port wins over core writes
`timescale 1ns/1ps

module word_ram
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
#(
    parameter int MEM_WORDS = 4096
) (
    input  logic     clk,
    input  mem_req_t mem_req,
    input  word_t    wr_data,
    input  prog_wr_t prog_wr,
    output word_t    rd_data
);

    // addresses wrap modulo the depth
    localparam int AW = $clog2(MEM_WORDS);

    word_t mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (prog_wr.wr) begin
            mem[prog_wr.addr[AW-1:0]] <= prog_wr.data;
        end else if (mem_req.wr) begin
            mem[mem_req.addr[AW-1:0]] <= wr_data;
        end
    end

    // data valid the cycle after the strobe
    always_ff @(posedge clk) begin
        if (mem_req.rd) begin
            rd_data <= mem[mem_req.addr[AW-1:0]];
        end
    end

endmodule

// ==== rtl/execute_unit.sv ====
// accumulator, zero/carry/sign flags and output register of the processor
`timescale 1ns/1ps

module execute_unit
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  acc_op_e acc_op,
    input  word_t   operand,
    output word_t   acc,
    output flags_t  flags,
    output word_t   out_word
);

    word_t  acc_next;
    flags_t flags_next;
    logic   acc_wr;

    always_comb begin
        acc_next   = acc;
        flags_next = flags;
        acc_wr     = 1'b1;
        case (acc_op)
            AC_LOAD: acc_next = operand;
            AC_ADD:  {flags_next.carry, acc_next} = {1'b0, acc} + {1'b0, operand};
            AC_SUB: begin
                // borrow
                flags_next.carry = (operand > acc);
                acc_next         = acc - operand;
            end
            AC_AND:  acc_next = acc & operand;
            AC_OR:   acc_next = acc | operand;
            AC_XOR:  acc_next = acc ^ operand;
            AC_INC:  {flags_next.carry, acc_next} = {1'b0, acc} + 17'd1;
            AC_DEC: begin
                flags_next.carry = (acc == '0);
                acc_next         = acc - 1'b1;
            end
            AC_NOT:  acc_next = ~acc;
            default: acc_wr = 1'b0;
        endcase
        if (acc_wr) begin
            flags_next.zero = (acc_next == '0);
            flags_next.sign = acc_next[15];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc   <= '0;
            flags <= '0;
        end else begin
            acc   <= acc_next;
            flags <= flags_next;
        end
    end

    // mwo and clo leave acc and flags alone
    always_ff @(posedge clk) begin
        if (reset) begin
            out_word <= '0;
        end else if (acc_op == AC_MWO) begin
            out_word <= acc;
        end else if (acc_op == AC_CLO) begin
            out_word <= '0;
        end
    end

endmodule

// ==== rtl/cpu_top.sv ====
// accumulator processor top level: sequencer, shared word memory and execute unit
`timescale 1ns/1ps

module cpu_top
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
#(
    parameter int MEM_WORDS = 4096
) (
    input  logic     clk,
    input  logic     reset,
    input  prog_wr_t prog_wr,
    output word_t    out_word
);

    mem_req_t mem_req;
    acc_op_e  acc_op;
    word_t    rd_data;
    word_t    acc;
    flags_t   flags;

    sequencer u_seq (
        .clk     (clk),
        .reset   (reset),
        .rd_data (rd_data),
        .flags   (flags),
        .mem_req (mem_req),
        .acc_op  (acc_op)
    );

    // stw writes the accumulator straight into memory
    word_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .clk     (clk),
        .mem_req (mem_req),
        .wr_data (acc),
        .prog_wr (prog_wr),
        .rd_data (rd_data)
    );

    execute_unit u_exec (
        .clk      (clk),
        .reset    (reset),
        .acc_op   (acc_op),
        .operand  (rd_data),
        .acc      (acc),
        .flags    (flags),
        .out_word (out_word)
    );

endmodule

// ==== tests/cpu_chk.sv ====
// sequencer protocol checks, bound into the sequencer
`timescale 1ns/1ps

module cpu_chk
    import cpu_ctrl_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input mem_req_t   mem_req,
    input seq_state_e state
);

    // single port, one strobe at a time
    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.rd && mem_req.wr))
        else $error("read and write strobes asserted together");

    a_exec_after_decode: assert property (@(posedge clk) disable iff (reset)
        (state == S_EXEC) |-> ($past(state) == S_DECODE))
        else $error("S_EXEC entered from a state other than S_DECODE");

    // state is back in S_FETCH one edge into reset
    a_quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !(mem_req.rd || mem_req.wr))
        else $error("memory strobe active during reset");

endmodule

// ==== tests/tb_clock_gen.sv ====
// testbench clock and power-on reset, reset also held while hold is high
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 16
) (
    input  logic hold,
    output logic clk,
    output logic reset
);

    logic por;
    int   count;

    initial begin
        clk   = 1'b0;
        por   = 1'b1;
        count = 0;
    end

    always #(PERIOD_NS / 2.0) clk = ~clk;

    // por stays high for RESET_CYCLES rising edges
    always @(posedge clk) begin
        if (por) begin
            count <= count + 1;
            if (count == RESET_CYCLES - 1) begin
                por <= 1'b0;
            end
        end
    end

    assign reset = por | hold;

endmodule

// ==== tests/cpu_tb.sv ====
// testbench for the accumulator processor: program builder, reference model and compare
`timescale 1ns/1ps

module cpu_tb
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
();

    localparam int    MEM_WORDS  = 1024;
    localparam int    LOAD_WORDS = 64;
    localparam int    MAX_STEPS  = 2000;
    localparam int    MAX_EXP    = 64;
    localparam word_t MARKER     = 16'h0a5c;

    logic     clk;
    logic     reset;
    logic     hold;
    prog_wr_t prog_wr;
    word_t    out_word;

    word_t       img [0:LOAD_WORDS-1];
    word_t       ref_mem [0:MEM_WORDS-1];
    word_t       exp_vals [0:MAX_EXP-1];
    int          exp_count;
    word_t       exp_final;
    int          wp;
    logic [31:0] rng_state = 32'hab48;

    logic  running = 1'b0;
    int    seen;
    word_t prev_out;
    int    value_errors = 0;
    int    order_errors = 0;
    int    cycle_count = 0;
    int    wd_limit = 500;

    tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(16)) u_clk (
        .hold  (hold),
        .clk   (clk),
        .reset (reset)
    );

    cpu_top #(.MEM_WORDS(MEM_WORDS)) u_dut (
        .clk      (clk),
        .reset    (reset),
        .prog_wr  (prog_wr),
        .out_word (out_word)
    );

    bind sequencer cpu_chk u_chk (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .state   (state)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // instruction level model of the image, returns the executed instruction count
    function automatic int run_reference();
        int          pc;
        int          next_pc;
        int          steps;
        int          i;
        logic        done;
        logic        zf;
        logic        cf;
        logic        sf;
        logic        wr_acc;
        word_t       acc;
        word_t       opnd;
        word_t       out;
        instr_t      ins;
        logic [16:0] wide;
        for (i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = (i < LOAD_WORDS) ? img[i] : '0;
        end
        pc = 0;
        steps = 0;
        done = 1'b0;
        {zf, cf, sf} = 3'b000;
        acc = '0;
        out = '0;
        exp_count = 0;
        while (!done && steps < MAX_STEPS) begin
            ins = instr_t'(ref_mem[pc]);
            opnd = ref_mem[ins.arg % MEM_WORDS];
            next_pc = (pc + 1) % MEM_WORDS;
            wr_acc = 1'b1;
            steps++;
            case (ins.opcode)
                OP_LDW: acc = opnd;
                OP_STW: begin
                    ref_mem[ins.arg % MEM_WORDS] = acc;
                    wr_acc = 1'b0;
                end
                OP_ADD: begin
                    wide = {1'b0, acc} + {1'b0, opnd};
                    cf = wide[16];
                    acc = wide[15:0];
                end
                OP_SUB: begin
                    cf = (opnd > acc);
                    acc = acc - opnd;
                end
                OP_AND: acc = acc & opnd;
                OP_OR:  acc = acc | opnd;
                OP_XOR: acc = acc ^ opnd;
                OP_NOARG: begin
                    case (noarg_e'(ins.arg[3:0]))
                        NA_INC: begin
                            wide = {1'b0, acc} + 17'd1;
                            cf = wide[16];
                            acc = wide[15:0];
                        end
                        NA_DEC: begin
                            cf = (acc == 16'h0000);
                            acc = acc - 16'd1;
                        end
                        NA_NOT: acc = ~acc;
                        NA_MWO: begin
                            if (acc != out && exp_count < MAX_EXP) begin
                                exp_vals[exp_count] = acc;
                                exp_count++;
                            end
                            out = acc;
                            wr_acc = 1'b0;
                        end
                        NA_CLO: begin
                            if (out != 16'h0000 && exp_count < MAX_EXP) begin
                                exp_vals[exp_count] = '0;
                                exp_count++;
                            end
                            out = '0;
                            wr_acc = 1'b0;
                        end
                        default: wr_acc = 1'b0;
                    endcase
                end
                OP_JMP: begin
                    done = (ins.arg == pc);
                    next_pc = ins.arg;
                    wr_acc = 1'b0;
                end
                OP_JPZ: begin
                    next_pc = zf ? int'(ins.arg) : next_pc;
                    wr_acc = 1'b0;
                end
                OP_JPC: begin
                    next_pc = cf ? int'(ins.arg) : next_pc;
                    wr_acc = 1'b0;
                end
                OP_JPS: begin
                    next_pc = sf ? int'(ins.arg) : next_pc;
                    wr_acc = 1'b0;
                end
                default: wr_acc = 1'b0;
            endcase
            if (wr_acc) begin
                zf = (acc == 16'h0000);
                sf = acc[15];
            end
            pc = next_pc;
        end
        exp_final = out;
        return steps;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic clear_image();
        int i;
        for (i = 0; i < LOAD_WORDS; i++) begin
            img[i] = '0;
        end
        wp = 0;
    endtask

    task automatic emit(input opcode_e op, input int arg);
        img[wp] = {op, addr_t'(arg)};
        wp++;
    endtask

    task automatic op_show(input opcode_e op, input int arg);
        emit(op, arg);
        emit(OP_NOARG, NA_MWO);
    endtask

    // conditional jump over a marker output
    task automatic skip_marker(input opcode_e op);
        int at;
        at = wp;
        emit(op, 0);
        op_show(OP_LDW, 49);
        img[at][11:0] = addr_t'(wp);
    endtask

    task automatic self_loop();
        emit(OP_JMP, wp);
    endtask

    // data at 40..49, 48 is the store target
    task automatic build_alu_program();
        int i;
        clear_image();
        for (i = 0; i < 6; i++) begin
            rng_state = xorshift32(rng_state);
            img[40 + i] = rng_state[15:0];
        end
        img[46] = 16'hffff;
        img[47] = 16'h0000;
        img[49] = MARKER;
        emit(OP_LDW, 40);
        emit(OP_STW, 48);
        emit(OP_LDW, 41);
        op_show(OP_LDW, 48);
        op_show(OP_LDW, 41);
        op_show(OP_ADD, 42);
        op_show(OP_SUB, 43);
        op_show(OP_AND, 44);
        op_show(OP_OR, 45);
        op_show(OP_XOR, 42);
        op_show(OP_NOARG, NA_NOT);
        // adding zero clears carry before the carry producing op
        emit(OP_LDW, 46);
        emit(OP_ADD, 47);
        op_show(OP_NOARG, NA_INC);
        skip_marker(OP_JPC);
        emit(OP_LDW, 47);
        emit(OP_ADD, 47);
        op_show(OP_NOARG, NA_DEC);
        skip_marker(OP_JPC);
        emit(OP_LDW, 40);
        emit(OP_NOARG, NA_INC);
        skip_marker(OP_JPC);
        self_loop();
    endtask

    task automatic build_flow_program();
        int loop_at;
        int fix;
        clear_image();
        img[49] = MARKER;
        img[50] = 16'd5;
        img[51] = 16'd1;
        img[52] = 16'h8000;
        emit(OP_LDW, 50);
        // counts 5 down to 1 on out_word
        loop_at = wp;
        emit(OP_NOARG, NA_MWO);
        emit(OP_NOARG, NA_DEC);
        fix = wp;
        emit(OP_JPZ, 0);
        emit(OP_JMP, loop_at);
        img[fix][11:0] = addr_t'(wp);
        emit(OP_NOARG, NA_MWO);
        emit(OP_LDW, 52);
        skip_marker(OP_JPS);
        emit(OP_LDW, 51);
        skip_marker(OP_JPS);
        emit(OP_LDW, 51);
        fix = wp;
        emit(OP_JPZ, 0);
        op_show(OP_XOR, 49);
        img[fix][11:0] = addr_t'(wp);
        emit(OP_NOARG, NA_CLO);
        self_loop();
    endtask

    task automatic run_program();
        int steps;
        int budget;
        int i;
        steps = run_reference();
        budget = steps * 3 + 20;
        wd_limit = wd_limit + budget + LOAD_WORDS + 8;
        @(posedge clk);
        hold <= 1'b1;
        for (i = 0; i < LOAD_WORDS; i++) begin
            @(posedge clk);
            prog_wr <= '{wr: 1'b1, addr: addr_t'(i), data: img[i]};
        end
        @(posedge clk);
        prog_wr <= '0;
        hold <= 1'b0;
        @(negedge clk);
        check_word(out_word, '0, "out_word after reset");
        @(posedge clk);
        seen = 0;
        prev_out = '0;
        running = 1'b1;
        repeat (budget) @(posedge clk);
        running = 1'b0;
        @(negedge clk);
        if (seen < exp_count) begin
            order_errors++;
            $display("out_word changed %0d times but %0d changes were expected", seen, exp_count);
        end
        check_word(out_word, exp_final, "final out_word");
    endtask

    // log every change of out_word in the order it happens
    always @(negedge clk) begin
        if (running && out_word !== prev_out) begin
            if (seen < exp_count) begin
                check_word(out_word, exp_vals[seen], $sformatf("out_word change %0d", seen));
            end else begin
                order_errors++;
                $display("out_word changed to %h at %0t with no change expected",
                         out_word, $time);
            end
            seen++;
            prev_out = out_word;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > wd_limit) begin
            $display("watchdog expired after %0d cycles before the tests finished", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int p;
        prog_wr = '0;
        hold = 1'b1;
        for (p = 0; p < 3; p++) begin
            if (p == 1) begin
                build_flow_program();
            end else begin
                build_alu_program();
            end
            run_program();
        end
        $display("errors: %0d value mismatches, %0d missing or extra output changes",
                 value_errors, order_errors);
        if (value_errors == 0 && order_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rtl/cpu_isa_pkg.sv
rtl/cpu_ctrl_pkg.sv
rtl/sequencer.sv
rtl/word_ram.sv
rtl/execute_unit.sv
rtl/cpu_top.sv
tests/cpu_chk.sv
tests/tb_clock_gen.sv
tests/cpu_tb.sv
